// ==== bench/softex_ctrl_tb.sv ====
/* Softmax controller testbench */

`timescale 1ns/1ps
`default_nettype none

module softex_ctrl_tb import softex_ctrl_pkg::*; ();

    localparam int TIMEOUT = 2000;

    logic clk_i, rst_ni;
    logic reg_we_i = 1'b0, start_i = 1'b0, slot_valid_i = 1'b0;
    logic in_beat_i = 1'b0, out_beat_i = 1'b0;
    logic [REG_ADDR_W-1:0] reg_addr_i = '0;
    logic [31:0] reg_wdata_i = '0;
    logic [NUM_LANES-1:0] lane_busy_i = '0, acc_pending_i = '0, inv_pending_i = '0;
    logic busy_o, done_o, in_start_o, out_start_o;
    logic [31:0] in_base_addr_o, out_base_addr_o;
    logic [LEN_W-1:0] in_len_o, out_len_o;
    logic [7:0] in_stride_o, out_stride_o;
    logic slot_req_valid_o, slot_update_valid_o;
    slot_op_e slot_req_op_o, slot_update_op_o;
    logic [15:0] slot_req_addr_o, slot_update_addr_o;
    logic dp_acc_only_o, dp_acc_finished_o, dp_dividing_o, dp_disable_max_o, dp_clear_regs_o;
    logic dp_load_max_o, dp_load_denominator_o, dp_load_reciprocal_o;

    integer seed = 32'h9230;
    string  cur_test = "reset";
    int in_left = 0, out_left = 0, busy_cnt = 0, acc_cnt = 0, inv_cnt = 0, slot_wait = 0;
    bit slot_drop = 1'b0;
    logic [NUM_LANES-1:0] lane_mask = '1;   // Lanes that the lane model holds
    // Pulse counts since the last done, and the expected values for the running case
    int n_in = 0, n_out = 0, n_both = 0, n_ldmax = 0, n_ldden = 0, n_ldrcp = 0;
    int n_req = 0, n_upd = 0, n_busy = 0, n_done = 0;
    int n_accfin = 0, n_div = 0, n_dismax = 0, n_clear = 0;
    int req_op = 0, req_addr = 0, upd_op = 0, upd_addr = 0;
    int e_in, e_out, e_both, e_ldmax, e_ldden, e_ldrcp, e_req, e_req_op, e_upd, e_upd_op;
    int e_slot;
    int e_accfin, e_div, e_dismax, e_clear;
    bit e_no_op;

    tb_clock_gen u_clock_gen (.clk_o(clk_i), .rst_no(rst_ni));

    softex_ctrl_top DUT (.*);

    function automatic int rand_range(input int lo, input int span);
        return lo + int'($unsigned($random(seed)) % span);
    endfunction

    // Expected beats, a partial last word still takes a full beat
    function automatic int ref_beats(input int len_bytes, input bit is_int);
        int bpb;
        bpb = is_int ? 8 : 16;
        return (len_bytes + bpb - 1) / bpb;
    endfunction

    task automatic check_value(input string what, input int exp_val, input int act_val);
        assert (exp_val == act_val) else begin
            $display("[ERROR] %s: %s expected %0d actual %0d", cur_test, what, exp_val, act_val);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout in %s while waiting for %s", cur_test, what);
        $display("Test failures found");
        $fatal(1);
    endtask

    // Stream, slot and lane models pick up events on the rising edge
    always @(posedge clk_i) begin
        if (in_start_o) in_left = int'(in_len_o);
        if (out_start_o) out_left = int'(out_len_o);
        if (slot_req_valid_o) slot_wait = rand_range(3, 6);
        if (slot_update_valid_o) slot_drop = 1'b1;
    end

    always @(negedge clk_i) begin
        in_beat_i  = 1'b0;
        out_beat_i = 1'b0;
        if (in_left > 0 && rand_range(0, 3) != 0) begin
            in_beat_i = 1'b1;
            in_left   = in_left - 1;
            if (in_left == 0 && !dp_dividing_o) busy_cnt = rand_range(2, 8);   // Lanes drain
        end
        if (out_left > 0 && rand_range(0, 3) != 0) begin
            out_beat_i = 1'b1;
            out_left   = out_left - 1;
        end
        if (busy_cnt > 0) begin
            busy_cnt = busy_cnt - 1;
            if (busy_cnt == 0) acc_cnt = rand_range(1, 6);
        end else if (acc_cnt > 0) begin
            acc_cnt = acc_cnt - 1;
            if (acc_cnt == 0 && !dp_acc_only_o) inv_cnt = rand_range(1, 6);
        end else if (inv_cnt > 0) begin
            inv_cnt = inv_cnt - 1;
        end
        lane_busy_i   = (busy_cnt > 0) ? lane_mask : '0;
        acc_pending_i = (acc_cnt > 0) ? lane_mask : '0;
        inv_pending_i = (inv_cnt > 0) ? lane_mask : '0;
        if (slot_drop) begin
            slot_valid_i = 1'b0;
            slot_drop    = 1'b0;
        end
        if (slot_wait > 0) begin
            slot_wait    = slot_wait - 1;
            slot_valid_i = (slot_wait == 0);
        end
    end

    // Checker counts strobes and compares them when a run ends
    always @(posedge clk_i) begin
        if (rst_ni) begin
            if (in_start_o) n_in++;
            if (out_start_o) n_out++;
            if (in_start_o && out_start_o) n_both++;
            if (dp_load_max_o) n_ldmax++;
            if (dp_load_denominator_o) n_ldden++;
            if (dp_load_reciprocal_o) n_ldrcp++;
            if (dp_acc_finished_o) n_accfin++;
            if (dp_dividing_o) n_div++;
            if (dp_disable_max_o) n_dismax++;
            if (dp_clear_regs_o) n_clear++;
            if (busy_o) n_busy++;
            if (slot_req_valid_o) begin
                n_req++;
                req_op   = int'(slot_req_op_o);
                req_addr = int'(slot_req_addr_o);
            end
            if (slot_update_valid_o) begin
                n_upd++;
                upd_op   = int'(slot_update_op_o);
                upd_addr = int'(slot_update_addr_o);
            end
            if (in_start_o && e_req != 0) check_value("slot valid at start", 1, int'(slot_valid_i));
            // Each wait may only end once every watched lane bit is low
            if (dp_acc_finished_o) check_value("lanes busy at acc_finished", 0, int'(|lane_busy_i));
            if (dp_dividing_o) check_value("acc pending while dividing", 0, int'(|acc_pending_i));
            if (done_o) begin
                check_value("lanes quiet at done", 0,
                            int'(|lane_busy_i || |acc_pending_i || |inv_pending_i));
                check_value("in_start pulses", e_in, n_in);
                check_value("out_start pulses", e_out, n_out);
                check_value("joint start pulses", e_both, n_both);
                check_value("load_max pulses", e_ldmax, n_ldmax);
                check_value("load_denominator pulses", e_ldden, n_ldden);
                check_value("load_reciprocal pulses", e_ldrcp, n_ldrcp);
                check_value("acc_finished seen", e_accfin, int'(n_accfin > 0));
                check_value("dividing seen", e_div, int'(n_div > 0));
                check_value("disable_max seen", e_dismax, int'(n_dismax > 0));
                check_value("clear_regs pulses", e_clear, n_clear);
                check_value("slot requests", e_req, n_req);
                check_value("slot updates", e_upd, n_upd);
                if (e_req != 0) check_value("request op", e_req_op, req_op);
                if (e_req != 0) check_value("request slot", e_slot, req_addr);
                if (e_upd != 0) check_value("update op", e_upd_op, upd_op);
                if (e_upd != 0) check_value("update slot", e_slot, upd_addr);
                check_value("busy at done", 0, int'(busy_o));
                if (e_no_op) check_value("done in start cycle", 1, int'(start_i));
                if (e_no_op) check_value("busy cycles", 0, n_busy);
                {n_in, n_out, n_both, n_ldmax, n_ldden, n_ldrcp} = '0;
                {n_req, n_upd, n_busy} = '0;
                {n_accfin, n_div, n_dismax, n_clear} = '0;
                n_done++;
            end
        end
    end

    task automatic expect_counts(input int in_s, input int out_s, input int both,
                                 input int ldmax, input int ldden, input int ldrcp);
        e_in    = in_s;
        e_out   = out_s;
        e_both  = both;
        e_ldmax = ldmax;
        e_ldden = ldden;
        e_ldrcp = ldrcp;
    endtask

    task automatic expect_slot(input int req, input slot_op_e r_op, input int upd,
                               input slot_op_e u_op, input int slot);
        e_req    = req;
        e_req_op = int'(r_op);
        e_upd    = upd;
        e_upd_op = int'(u_op);
        e_slot   = slot;
    endtask

    // Which datapath strobes a run raises, and how many clear pulses it gives
    task automatic want_strobes(input int acc_fin, input int dividing, input int dis_max,
                                input int clear);
        e_accfin = acc_fin;
        e_div    = dividing;
        e_dismax = dis_max;
        e_clear  = clear;
    endtask

    task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] data);
        reg_we_i    = 1'b1;
        reg_addr_i  = addr;
        reg_wdata_i = data;
        @(negedge clk_i);
        reg_we_i    = 1'b0;
    endtask

    task automatic run_case(input string name, input int len, input logic [31:0] cmd);
        int base;
        int i;
        cur_test = name;
        i = 0;
        while (busy_o || busy_cnt != 0 || acc_cnt != 0 || inv_cnt != 0 || slot_wait != 0 ||
               in_left != 0 || out_left != 0) begin
            if (i == TIMEOUT) report_timeout("the models to settle");
            i++;
            @(negedge clk_i);
        end
        write_reg(REG_IN_ADDR, 32'h1000_0000);
        write_reg(REG_OUT_ADDR, 32'h2000_0000);
        write_reg(REG_TOT_LEN, len);
        write_reg(REG_COMMANDS, cmd);
        check_value("in_base", 32'h1000_0000, int'(in_base_addr_o));
        check_value("out_base", 32'h2000_0000, int'(out_base_addr_o));
        check_value("dp_acc_only", int'(cmd[CMD_ACC_ONLY] && !cmd[CMD_LAST]),
                    int'(dp_acc_only_o));
        check_value("in_len", ref_beats(len, cmd[CMD_INT_INPUT]), int'(in_len_o));
        check_value("out_len", ref_beats(len, cmd[CMD_INT_OUTPUT]), int'(out_len_o));
        check_value("in_stride", cmd[CMD_INT_INPUT] ? 8 : 16, int'(in_stride_o));
        check_value("out_stride", cmd[CMD_INT_OUTPUT] ? 8 : 16, int'(out_stride_o));
        base    = n_done;
        start_i = 1'b1;
        @(negedge clk_i);
        start_i = 1'b0;
        i = 0;
        while (n_done == base) begin
            if (i == TIMEOUT) report_timeout("done");
            i++;
            @(negedge clk_i);
        end
    endtask

    initial begin
        int i;
        e_no_op = 1'b0;
        i = 0;
        while (!rst_ni) begin
            if (i == TIMEOUT) report_timeout("reset release");
            i++;
            @(negedge clk_i);
        end
        @(negedge clk_i);

        expect_counts(2, 1, 1, 0, 0, 0);
        expect_slot(0, ALLOC, 0, UPDATE, 0);
        want_strobes(1, 1, 1, 1);
        run_case("full_float", 100, 32'h0);

        run_case("int_in_float_out", 100, 32'h1 << CMD_INT_INPUT);

        expect_counts(1, 0, 0, 0, 0, 0);
        expect_slot(1, ALLOC, 1, UPDATE, 16'h002A);
        want_strobes(1, 0, 1, 1);
        run_case("acc_only_acquire", 64,
                 (32'h002A << SLOT_ID_LSB) | (32'h1 << CMD_ACC_ONLY) | (32'h1 << CMD_ACQUIRE_SLOT));

        expect_counts(1, 1, 1, 1, 0, 1);
        expect_slot(1, LOAD, 1, FREE, 16'h002A);
        want_strobes(0, 1, 1, 1);
        run_case("div_only_last", 64,
                 (32'h002A << SLOT_ID_LSB) | (32'h1 << CMD_DIV_ONLY) | (32'h1 << CMD_LAST));

        expect_counts(0, 0, 0, 0, 0, 0);
        expect_slot(0, ALLOC, 0, UPDATE, 0);
        want_strobes(0, 0, 0, 0);
        e_no_op = 1'b1;
        run_case("no_op", 64, 32'h1 << CMD_NO_OP);
        e_no_op = 1'b0;

        // A single lane holds each wait, so one high bit must be enough to stall
        expect_counts(2, 1, 1, 0, 0, 0);
        want_strobes(1, 1, 1, 1);
        lane_mask = '0;
        lane_mask[NUM_LANES-1] = 1'b1;
        run_case("lane_waits", 40, 32'h1 << CMD_INT_OUTPUT);

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
/* Bench clock and reset */

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;   // 20 ns period
    end

    // Reset held low for two rising edges, released on a falling edge
    initial begin
        rst_no = 1'b0;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module softex_ctrl_tb \
    -o softex_ctrl_sim > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/softex_ctrl_sim > sim.log 2>&1 || true

cat sim.log

grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== sim.f ====
source/softex_ctrl_pkg.sv
source/softex_cmd_regs.sv
source/softex_stream_cfg.sv
source/softex_beat_counter.sv
source/softex_ctrl_fsm.sv
source/softex_ctrl_top.sv
bench/tb_clock_gen.sv
bench/softex_ctrl_tb.sv

// ==== source/softex_beat_counter.sv ====
/* Stream pass beat counter */

`timescale 1ns/1ps
`default_nettype none

module softex_beat_counter import softex_ctrl_pkg::*; (
    input  wire logic             clk_i,
    input  wire logic             rst_ni,
    input  wire logic             start_i,
    input  wire logic [LEN_W-1:0] len_i,
    input  wire logic             beat_i,
    output logic                  done_o
);

    logic             active_q;
    logic [LEN_W-1:0] cnt_q;   // Beats still expected in this pass

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            active_q <= 1'b0;
            cnt_q    <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                cnt_q <= len_i;
                if (len_i == '0) begin
                    done_o <= 1'b1;   // Empty pass ends right away
                end else begin
                    active_q <= 1'b1;
                end
            end else if (active_q && beat_i) begin
                cnt_q <= cnt_q - 1'b1;
                if (cnt_q == LEN_W'(1)) begin
                    active_q <= 1'b0;
                    done_o   <= 1'b1;
                end
            end
        end
    end

    // The controller never restarts a pass that is still running
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        start_i |-> !active_q);

endmodule

`default_nettype wire

// ==== source/softex_cmd_regs.sv ====
/* Parameter registers and command decode */

`timescale 1ns/1ps
`default_nettype none

module softex_cmd_regs import softex_ctrl_pkg::*; (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire logic                  reg_we_i,
    input  wire logic [REG_ADDR_W-1:0] reg_addr_i,
    input  wire logic [31:0]           reg_wdata_i,
    input  wire logic                  busy_i,
    output logic [31:0]                in_base_addr_o,
    output logic [31:0]                out_base_addr_o,
    output logic [31:0]                tot_len_o,
    output logic                       acc_only_o,
    output logic                       div_only_o,
    output logic                       last_o,
    output logic                       acquire_slot_o,
    output logic                       no_op_o,
    output logic                       int_input_o,
    output logic                       int_output_o,
    output logic [15:0]                slot_id_o,
    output logic                       slot_req_valid_o,
    output slot_op_e                   slot_req_op_o,
    output logic [15:0]                slot_req_addr_o,
    output logic                       dp_acc_only_o
);

    logic        wr_en;
    logic [31:0] cmd_q;

    assign wr_en = reg_we_i & ~busy_i;   // Parameters are frozen during a run

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            in_base_addr_o  <= '0;
            out_base_addr_o <= '0;
            tot_len_o       <= '0;
            cmd_q           <= '0;
        end else if (wr_en) begin
            case (reg_addr_i)
                REG_IN_ADDR:  in_base_addr_o  <= reg_wdata_i;
                REG_OUT_ADDR: out_base_addr_o <= reg_wdata_i;
                REG_TOT_LEN:  tot_len_o       <= reg_wdata_i;
                default:      cmd_q           <= reg_wdata_i;
            endcase
        end
    end

    assign acc_only_o     = cmd_q[CMD_ACC_ONLY];      // Stop once the denominator is ready
    assign div_only_o     = cmd_q[CMD_DIV_ONLY];      // Normalise with max and denominator from the slot
    assign last_o         = cmd_q[CMD_LAST];
    assign acquire_slot_o = cmd_q[CMD_ACQUIRE_SLOT];  // First partial iteration of a new vector
    assign no_op_o        = cmd_q[CMD_NO_OP];
    assign int_input_o    = cmd_q[CMD_INT_INPUT];
    assign int_output_o   = cmd_q[CMD_INT_OUTPUT];
    assign slot_id_o      = cmd_q[SLOT_ID_LSB +: 16];

    // Lanes keep their partial sums un-inverted between partial accumulations
    assign dp_acc_only_o = acc_only_o & ~last_o;

    // The slot store is asked as soon as a partial command is written
    assign slot_req_valid_o = wr_en && (reg_addr_i == REG_COMMANDS) &&
                              (reg_wdata_i[CMD_ACC_ONLY] || reg_wdata_i[CMD_DIV_ONLY]);
    assign slot_req_op_o    = reg_wdata_i[CMD_ACQUIRE_SLOT] ? ALLOC : LOAD;
    assign slot_req_addr_o  = reg_wdata_i[SLOT_ID_LSB +: 16];

    // A partial command selects either accumulation or division, never both
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        slot_req_valid_o |-> !(reg_wdata_i[CMD_ACC_ONLY] && reg_wdata_i[CMD_DIV_ONLY]));

endmodule

`default_nettype wire

// ==== source/softex_ctrl_fsm.sv ====
/* Softmax sequencing FSM */

`timescale 1ns/1ps
`default_nettype none

module softex_ctrl_fsm import softex_ctrl_pkg::*; (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    input  wire logic                 start_i,
    input  wire logic                 acc_only_i,
    input  wire logic                 div_only_i,
    input  wire logic                 last_i,
    input  wire logic                 acquire_slot_i,
    input  wire logic                 no_op_i,
    input  wire logic [15:0]          slot_id_i,
    input  wire logic                 slot_valid_i,
    input  wire logic                 in_done_i,
    input  wire logic                 out_done_i,
    input  wire logic [NUM_LANES-1:0] lane_busy_i,
    input  wire logic [NUM_LANES-1:0] acc_pending_i,
    input  wire logic [NUM_LANES-1:0] inv_pending_i,
    output logic                      in_start_o,
    output logic                      out_start_o,
    output logic                      busy_o,
    output logic                      done_o,
    output logic                      dp_acc_finished_o,
    output logic                      dp_dividing_o,
    output logic                      dp_disable_max_o,
    output logic                      dp_clear_regs_o,
    output logic                      dp_load_max_o,
    output logic                      dp_load_denominator_o,
    output logic                      dp_load_reciprocal_o,
    output logic                      slot_update_valid_o,
    output slot_op_e                  slot_update_op_o,
    output logic [15:0]               slot_update_addr_o
);

    ctrl_state_e state_q, state_d;

    logic partial;
    logic launch;      // First pass begins this cycle
    logic load_slot;

    assign partial = acc_only_i | div_only_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d             = state_q;
        launch              = 1'b0;
        load_slot           = 1'b0;
        in_start_o          = 1'b0;
        out_start_o         = 1'b0;
        busy_o              = 1'b1;
        done_o              = 1'b0;
        dp_acc_finished_o   = 1'b0;
        dp_dividing_o       = 1'b0;
        dp_disable_max_o    = 1'b0;
        dp_clear_regs_o     = 1'b0;
        slot_update_valid_o = 1'b0;

        case (state_q)
            IDLE: begin
                busy_o = 1'b0;
                if (start_i) begin
                    if (no_op_i) begin
                        done_o = 1'b1;
                    end else if (partial && !slot_valid_i) begin
                        state_d = WAIT_SLOT_VALID;   // Slot store has not answered yet
                    end else begin
                        launch = 1'b1;
                    end
                end
            end
            WAIT_SLOT_VALID: launch = slot_valid_i;
            ACCUMULATION: begin
                if (in_done_i) state_d = WAIT_DATAPATH_EMPTY;
            end
            WAIT_DATAPATH_EMPTY: begin
                if (~|lane_busy_i) begin
                    state_d           = WAIT_ACCUMULATION;
                    dp_acc_finished_o = 1'b1;
                end
            end
            WAIT_ACCUMULATION: begin
                dp_acc_finished_o = 1'b1;
                dp_disable_max_o  = 1'b1;
                if (~|acc_pending_i) begin
                    if (acc_only_i && !last_i) begin
                        state_d = FINISHED;
                    end else begin
                        state_d = WAIT_INVERSION;
                        if (!acc_only_i) begin
                            // Second pass reads the input again and writes the output
                            dp_acc_finished_o = 1'b0;
                            in_start_o        = 1'b1;
                            out_start_o       = 1'b1;
                        end
                    end
                end
            end
            WAIT_INVERSION: begin
                dp_dividing_o    = 1'b1;
                dp_disable_max_o = 1'b1;
                if (~|inv_pending_i) state_d = acc_only_i ? FINISHED : DIVIDING;
            end
            DIVIDING: begin
                dp_dividing_o    = 1'b1;
                dp_disable_max_o = 1'b1;
                if (out_done_i) state_d = FINISHED;
            end
            default: begin   // FINISHED
                busy_o              = 1'b0;
                done_o              = 1'b1;
                dp_clear_regs_o     = 1'b1;
                slot_update_valid_o = acc_only_i | (div_only_i & last_i);
                state_d             = IDLE;
            end
        endcase

        if (launch) begin
            in_start_o  = 1'b1;
            out_start_o = div_only_i;   // Divide-only reads and writes together
            state_d     = div_only_i ? DIVIDING : ACCUMULATION;
            load_slot   = partial & ~acquire_slot_i;
        end
    end

    // Lanes restore their state from the slot unless it was just allocated
    assign dp_load_max_o         = load_slot;
    assign dp_load_denominator_o = load_slot & acc_only_i;
    assign dp_load_reciprocal_o  = load_slot & ~acc_only_i;

    assign slot_update_op_o   = (last_i && div_only_i) ? FREE : UPDATE;
    assign slot_update_addr_o = slot_id_i;

    // The end of the output pass is only taken while dividing, a pulse elsewhere is lost
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        out_done_i |-> (state_q == DIVIDING));

endmodule

`default_nettype wire

// ==== source/softex_ctrl_pkg.sv ====
/* Softmax controller shared definitions */

`default_nettype none

package softex_ctrl_pkg;

    // Stream geometry
    localparam int unsigned DATA_WIDTH     = 128;
    localparam int unsigned BEAT_BYTES     = DATA_WIDTH / 8;   // 16-bit floats
    localparam int unsigned INT_BEAT_BYTES = BEAT_BYTES / 2;   // 8-bit integers take half a word
    localparam int unsigned NUM_LANES      = 4;
    localparam int unsigned LEN_W          = 28;

    // Parameter register map, one 32-bit word per index
    localparam int unsigned REG_ADDR_W = 2;

    localparam logic [REG_ADDR_W-1:0] REG_IN_ADDR  = 2'd0;
    localparam logic [REG_ADDR_W-1:0] REG_OUT_ADDR = 2'd1;
    localparam logic [REG_ADDR_W-1:0] REG_TOT_LEN  = 2'd2;   // Vector length in bytes
    localparam logic [REG_ADDR_W-1:0] REG_COMMANDS = 2'd3;

    // Bit positions inside the command word
    localparam int unsigned CMD_ACC_ONLY     = 0;
    localparam int unsigned CMD_DIV_ONLY     = 1;
    localparam int unsigned CMD_LAST         = 2;
    localparam int unsigned CMD_ACQUIRE_SLOT = 3;
    localparam int unsigned CMD_NO_OP        = 4;
    localparam int unsigned CMD_INT_INPUT    = 5;
    localparam int unsigned CMD_INT_OUTPUT   = 6;

    // The slot identifier occupies the upper half of the command word
    localparam int unsigned SLOT_ID_LSB = 16;

    typedef enum logic [1:0] {
        ALLOC,
        LOAD,
        UPDATE,
        FREE
    } slot_op_e;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_SLOT_VALID,
        ACCUMULATION,
        WAIT_DATAPATH_EMPTY,
        WAIT_ACCUMULATION,
        WAIT_INVERSION,
        DIVIDING,
        FINISHED
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== source/softex_ctrl_top.sv ====
/* Softmax controller top level */

`timescale 1ns/1ps
`default_nettype none

module softex_ctrl_top import softex_ctrl_pkg::*; (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire logic                  reg_we_i,
    input  wire logic [REG_ADDR_W-1:0] reg_addr_i,
    input  wire logic [31:0]           reg_wdata_i,
    input  wire logic                  start_i,
    input  wire logic                  slot_valid_i,
    input  wire logic                  in_beat_i,
    input  wire logic                  out_beat_i,
    input  wire logic [NUM_LANES-1:0]  lane_busy_i,
    input  wire logic [NUM_LANES-1:0]  acc_pending_i,
    input  wire logic [NUM_LANES-1:0]  inv_pending_i,
    output logic                       busy_o,
    output logic                       done_o,
    output logic                       in_start_o,
    output logic                       out_start_o,
    output logic [31:0]                in_base_addr_o,
    output logic [31:0]                out_base_addr_o,
    output logic [LEN_W-1:0]           in_len_o,
    output logic [LEN_W-1:0]           out_len_o,
    output logic [7:0]                 in_stride_o,
    output logic [7:0]                 out_stride_o,
    output logic                       slot_req_valid_o,
    output slot_op_e                   slot_req_op_o,
    output logic [15:0]                slot_req_addr_o,
    output logic                       slot_update_valid_o,
    output slot_op_e                   slot_update_op_o,
    output logic [15:0]                slot_update_addr_o,
    output logic                       dp_acc_only_o,
    output logic                       dp_acc_finished_o,
    output logic                       dp_dividing_o,
    output logic                       dp_disable_max_o,
    output logic                       dp_clear_regs_o,
    output logic                       dp_load_max_o,
    output logic                       dp_load_denominator_o,
    output logic                       dp_load_reciprocal_o
);

    logic [31:0] tot_len;
    logic        acc_only, div_only, last, acquire_slot, no_op;
    logic        int_input, int_output;
    logic [15:0] slot_id;
    logic        in_done, out_done;

    softex_cmd_regs u_cmd_regs (
        .clk_i, .rst_ni, .reg_we_i, .reg_addr_i, .reg_wdata_i,
        .busy_i          (busy_o),
        .in_base_addr_o, .out_base_addr_o,
        .tot_len_o       (tot_len),
        .acc_only_o      (acc_only),
        .div_only_o      (div_only),
        .last_o          (last),
        .acquire_slot_o  (acquire_slot),
        .no_op_o         (no_op),
        .int_input_o     (int_input),
        .int_output_o    (int_output),
        .slot_id_o       (slot_id),
        .slot_req_valid_o, .slot_req_op_o, .slot_req_addr_o, .dp_acc_only_o
    );

    softex_stream_cfg u_stream_cfg (
        .tot_len_i    (tot_len),
        .int_input_i  (int_input),
        .int_output_i (int_output),
        .in_len_o, .out_len_o, .in_stride_o, .out_stride_o
    );

    softex_beat_counter u_in_counter (
        .clk_i, .rst_ni,
        .start_i (in_start_o),
        .len_i   (in_len_o),
        .beat_i  (in_beat_i),
        .done_o  (in_done)
    );

    softex_beat_counter u_out_counter (
        .clk_i, .rst_ni,
        .start_i (out_start_o),
        .len_i   (out_len_o),
        .beat_i  (out_beat_i),
        .done_o  (out_done)
    );

    softex_ctrl_fsm u_fsm (
        .clk_i, .rst_ni, .start_i,
        .acc_only_i     (acc_only),
        .div_only_i     (div_only),
        .last_i         (last),
        .acquire_slot_i (acquire_slot),
        .no_op_i        (no_op),
        .slot_id_i      (slot_id),
        .slot_valid_i,
        .in_done_i      (in_done),
        .out_done_i     (out_done),
        .lane_busy_i, .acc_pending_i, .inv_pending_i,
        .in_start_o, .out_start_o, .busy_o, .done_o,
        .dp_acc_finished_o, .dp_dividing_o, .dp_disable_max_o, .dp_clear_regs_o,
        .dp_load_max_o, .dp_load_denominator_o, .dp_load_reciprocal_o,
        .slot_update_valid_o, .slot_update_op_o, .slot_update_addr_o
    );

endmodule

`default_nettype wire

// ==== source/softex_stream_cfg.sv ====
/* Stream length and stride setup */

`timescale 1ns/1ps
`default_nettype none

module softex_stream_cfg import softex_ctrl_pkg::*; (
    input  wire logic [31:0] tot_len_i,
    input  wire logic        int_input_i,
    input  wire logic        int_output_i,
    output logic [LEN_W-1:0] in_len_o,
    output logic [LEN_W-1:0] out_len_o,
    output logic [7:0]       in_stride_o,
    output logic [7:0]       out_stride_o
);

    localparam int unsigned FLT_SHIFT = $clog2(BEAT_BYTES);
    localparam int unsigned INT_SHIFT = $clog2(INT_BEAT_BYTES);

    // Beats needed for a byte length, a partial last word counts as one
    function automatic logic [LEN_W-1:0] beats_f(input logic [31:0] len_bytes,
                                                 input logic        is_int);
        logic [31:0] quot;
        logic        rem;
        if (is_int) begin
            quot = len_bytes >> INT_SHIFT;
            rem  = |len_bytes[INT_SHIFT-1:0];
        end else begin
            quot = len_bytes >> FLT_SHIFT;
            rem  = |len_bytes[FLT_SHIFT-1:0];
        end
        return quot[LEN_W-1:0] + LEN_W'(rem);
    endfunction

    function automatic logic [7:0] stride_f(input logic is_int);
        return is_int ? 8'(INT_BEAT_BYTES) : 8'(BEAT_BYTES);
    endfunction

    assign in_len_o     = beats_f(tot_len_i, int_input_i);
    assign out_len_o    = beats_f(tot_len_i, int_output_i);
    assign in_stride_o  = stride_f(int_input_i);    // Words are packed back to back
    assign out_stride_o = stride_f(int_output_i);

endmodule

`default_nettype wire
